// ==== common/exu_pkg.sv ====
/*
 Shared definitions for the RV32 execute stage.
 Holds the data widths, the decode group, the per-unit operation views
 and the decode union that dispatch hands to the ALU, branch and M units.
 Design and testbench refer to everything here by package-scoped names.
 */
`default_nettype none

package exu_pkg;

    // register width, fixed to RV32
    localparam int XLEN = 32;
    // link value offset for jal and jalr
    localparam int INST_BYTES = 4;
    // iterations of the multiply and divide loop
    localparam int MD_STEPS = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;

    // selects which unit owns the instruction
    typedef enum logic [1:0] {
        GRP_NONE   = 2'd0,
        GRP_ALU    = 2'd1,
        GRP_BJP    = 2'd2,
        GRP_MULDIV = 2'd3
    } exu_grp_e;

    // one-hot ALU ops, op2_imm picks the immediate as second operand
    typedef struct packed {
        logic op2_imm;
        logic op_lui;
        logic op_auipc;
        logic op_add;
        logic op_sub;
        logic op_sll;
        logic op_slt;
        logic op_sltu;
        logic op_xor;
        logic op_srl;
        logic op_sra;
        logic op_or;
        logic op_and;
    } alu_ops_t;

    // one-hot branch and jump ops
    typedef struct packed {
        logic [4:0] pad;
        logic       op_jal;
        logic       op_jalr;
        logic       op_beq;
        logic       op_bne;
        logic       op_blt;
        logic       op_bltu;
        logic       op_bge;
        logic       op_bgeu;
    } bjp_ops_t;

    // M extension, order follows funct3
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
        MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } muldiv_op_e;

    typedef struct packed {
        logic [9:0] pad;
        muldiv_op_e op;
    } muldiv_ops_t;

    // same 13-bit word, meaning depends on the group
    typedef union packed {
        alu_ops_t    alu;
        bjp_ops_t    bjp;
        muldiv_ops_t md;
    } dec_ops_u;

    typedef struct packed {
        exu_grp_e grp;
        dec_ops_u ops;
    } dec_info_t;

endpackage

`default_nettype wire

// ==== common/issue_if.sv ====
/*
 Issue bundle from dispatch to the three execute units.
 Purely combinational from the current instruction, no handshake.
 At most one of the request bits is high in any cycle.
 */
`timescale 1ns/1ns
`default_nettype none

interface issue_if;

    // one request per unit
    logic              alu_req;
    logic              bjp_req;
    logic              md_req;
    // decoded ops, read through the view of the owning unit
    exu_pkg::dec_ops_u ops;
    // operands already formed per unit
    exu_pkg::data_t    op1;
    exu_pkg::data_t    op2;
    exu_pkg::data_t    jump_base;
    exu_pkg::data_t    imm;

    modport dispatch (output alu_req, bjp_req, md_req, ops, op1, op2, jump_base, imm);
    modport alu      (input alu_req, ops, op1, op2);
    modport bru      (input bjp_req, ops, op1, op2, jump_base, imm);
    modport muldiv   (input md_req, ops, op1, op2);

endinterface

`default_nettype wire

// ==== common/muldiv_if.sv ====
/*
 Start, busy and done handshake between the multiply/divide control
 and its iterative core. start is taken only while busy is low,
 done pulses one cycle with the result, kill drops back to idle.
 */
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if;

    logic                start;
    logic                kill;
    exu_pkg::muldiv_op_e op;
    exu_pkg::data_t      op1;
    exu_pkg::data_t      op2;
    logic                busy;
    logic                done;
    exu_pkg::data_t      result;

    modport ctrl (output start, kill, op, op1, op2, input busy, done, result);
    modport core (input start, kill, op, op1, op2, output busy, done, result);

endinterface

`default_nettype wire

// ==== hw/exu_dispatch.sv ====
/*
 Dispatch for the execute stage.
 Turns the decode group into one unit request and forms the operands
 each unit expects. Requests are dropped while an interrupt is taken.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_dispatch (
    input  wire exu_pkg::dec_info_t dec_info_i,
    input  wire exu_pkg::data_t     dec_imm_i,
    input  wire exu_pkg::data_t     pc_i,
    input  wire exu_pkg::data_t     rs1_rdata_i,
    input  wire exu_pkg::data_t     rs2_rdata_i,
    input  wire                     int_assert_i,
    issue_if.dispatch               iss
);

    exu_pkg::alu_ops_t alu_ops;
    exu_pkg::bjp_ops_t bjp_ops;

    // two views of the same decode word
    assign alu_ops = dec_info_i.ops.alu;
    assign bjp_ops = dec_info_i.ops.bjp;

    assign iss.alu_req = (dec_info_i.grp == exu_pkg::GRP_ALU) & ~int_assert_i;
    assign iss.bjp_req = (dec_info_i.grp == exu_pkg::GRP_BJP) & ~int_assert_i;
    assign iss.md_req  = (dec_info_i.grp == exu_pkg::GRP_MULDIV) & ~int_assert_i;
    assign iss.ops     = dec_info_i.ops;
    assign iss.imm     = dec_imm_i;

    always_comb begin
        // register operands unless the op says otherwise
        iss.op1       = rs1_rdata_i;
        iss.op2       = rs2_rdata_i;
        iss.jump_base = pc_i;
        case (dec_info_i.grp)
            exu_pkg::GRP_ALU: begin
                if (alu_ops.op_auipc) begin
                    iss.op1 = pc_i;
                    iss.op2 = dec_imm_i;
                end else if (alu_ops.op_lui) begin
                    // lui rides on the adder with a zero base
                    iss.op1 = '0;
                    iss.op2 = dec_imm_i;
                end else if (alu_ops.op2_imm) begin
                    iss.op2 = dec_imm_i;
                end
            end
            exu_pkg::GRP_BJP: begin
                // jumps have no compare, op1 carries pc for the link
                if (bjp_ops.op_jal | bjp_ops.op_jalr) begin
                    iss.op1 = pc_i;
                end
                if (bjp_ops.op_jalr) begin
                    iss.jump_base = rs1_rdata_i;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exu_alu.sv ====
/*
 Integer ALU for RV32I register and immediate forms.
 Combinational, the op vector is one-hot so results are AND-OR merged.
 lui and auipc arrive from dispatch as plain additions.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
    issue_if.alu                 iss,
    output logic                 alu_we_o,
    output exu_pkg::data_t       alu_result_o
);

    exu_pkg::alu_ops_t ops;
    exu_pkg::data_t    sum;
    exu_pkg::data_t    diff;
    logic [4:0]        shamt;
    logic              lt_s;
    logic              lt_u;

    assign ops   = iss.ops.alu;
    assign sum   = iss.op1 + iss.op2;
    assign diff  = iss.op1 - iss.op2;
    // shifts use the low five bits only
    assign shamt = iss.op2[4:0];
    assign lt_s  = $signed(iss.op1) < $signed(iss.op2);
    assign lt_u  = iss.op1 < iss.op2;

    assign alu_result_o =
          ({exu_pkg::XLEN{ops.op_add | ops.op_lui | ops.op_auipc}} & sum)
        | ({exu_pkg::XLEN{ops.op_sub}}  & diff)
        | ({exu_pkg::XLEN{ops.op_sll}}  & (iss.op1 << shamt))
        | ({exu_pkg::XLEN{ops.op_slt}}  & exu_pkg::data_t'(lt_s))
        | ({exu_pkg::XLEN{ops.op_sltu}} & exu_pkg::data_t'(lt_u))
        | ({exu_pkg::XLEN{ops.op_xor}}  & (iss.op1 ^ iss.op2))
        | ({exu_pkg::XLEN{ops.op_srl}}  & (iss.op1 >> shamt))
        | ({exu_pkg::XLEN{ops.op_sra}}  & exu_pkg::data_t'($signed(iss.op1) >>> shamt))
        | ({exu_pkg::XLEN{ops.op_or}}   & (iss.op1 | iss.op2))
        | ({exu_pkg::XLEN{ops.op_and}}  & (iss.op1 & iss.op2));

    // every ALU op writes rd
    assign alu_we_o = iss.alu_req;

endmodule

`default_nettype wire

// ==== hw/exu_bru.sv ====
/*
 Branch and jump unit.
 Compares rs1 and rs2 for conditional branches, forms the target from
 the jump base and immediate, and gives the link value for jal and jalr.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_bru (
    issue_if.bru                 iss,
    output logic                 bru_jump_o,
    output exu_pkg::data_t       bru_target_o,
    output logic                 bru_we_o,
    output exu_pkg::data_t       bru_link_o
);

    exu_pkg::bjp_ops_t ops;
    exu_pkg::data_t    target;
    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              cond;
    logic              is_jump;

    assign ops  = iss.ops.bjp;
    assign eq   = iss.op1 == iss.op2;
    assign lt_s = $signed(iss.op1) < $signed(iss.op2);
    assign lt_u = iss.op1 < iss.op2;

    // branch condition, ge is the inverse of lt
    assign cond = (ops.op_beq  & eq)   | (ops.op_bne  & ~eq)
                | (ops.op_blt  & lt_s) | (ops.op_bge  & ~lt_s)
                | (ops.op_bltu & lt_u) | (ops.op_bgeu & ~lt_u);

    assign is_jump    = ops.op_jal | ops.op_jalr;
    assign bru_jump_o = iss.bjp_req & (is_jump | cond);

    assign target = iss.jump_base + iss.imm;
    // jalr clears bit zero
    assign bru_target_o = {target[exu_pkg::XLEN-1:1], target[0] & ~ops.op_jalr};

    // op1 holds pc for jumps
    assign bru_we_o   = iss.bjp_req & is_jump;
    assign bru_link_o = iss.op1 + exu_pkg::data_t'(exu_pkg::INST_BYTES);

endmodule

`default_nettype wire

// ==== hw/muldiv/exu_muldiv_ctrl.sv ====
/*
 Control for multi-cycle multiply and divide.
 Starts the core once per held instruction, holds upstream until done,
 writes the result back on done and kills the core on interrupt.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_muldiv_ctrl (
    input  wire                  clk,
    input  wire                  rst_n_i,
    issue_if.muldiv              iss,
    input  wire                  int_assert_i,
    muldiv_if.ctrl               md,
    output logic                 md_hold_o,
    output logic                 md_we_o,
    output exu_pkg::data_t       md_result_o
);

    // current instruction already handed to the core
    logic started_q;

    // only the first idle cycle of a request starts
    assign md.start = iss.md_req & ~started_q & ~md.busy;
    assign md.kill  = int_assert_i;
    assign md.op    = iss.ops.md.op;
    assign md.op1   = iss.op1;
    assign md.op2   = iss.op2;

    // hold drops in the done cycle so the write retires with it
    assign md_hold_o   = iss.md_req & ~md.done;
    assign md_we_o     = iss.md_req & md.done;
    assign md_result_o = md.result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            started_q <= 1'b0;
        end else if (md.kill || md.done) begin
            started_q <= 1'b0;
        end else if (md.start) begin
            started_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/muldiv/exu_muldiv_core.sv ====
/*
 Iterative core for the M extension.
 Works on magnitudes: 32 shift-add steps for multiply, 32 restoring
 steps for divide, then one cycle to restore sign and pick the half.
 hi/lo hold partial product, or remainder and quotient.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_muldiv_core (
    input  wire    clk,
    input  wire    rst_n_i,
    muldiv_if.core md
);

    localparam int CNT_W = $clog2(exu_pkg::MD_STEPS);

    logic                run_q;
    logic                fix_q;
    logic                done_q;
    logic [CNT_W-1:0]    cnt_q;
    exu_pkg::muldiv_op_e op_q;
    logic                div_q;
    logic                neg_res_q;
    logic                neg_rem_q;
    exu_pkg::data_t      hi_q;
    exu_pkg::data_t      lo_q;
    exu_pkg::data_t      opnd_q;
    exu_pkg::data_t      result_q;
    logic                accept;
    logic                last_step;
    logic                is_div;
    logic                neg1;
    logic                neg2;
    exu_pkg::data_t      mag1;
    exu_pkg::data_t      mag2;
    logic [32:0]         add_sum;
    logic [33:0]         sub_diff;
    logic [63:0]         prod_fix;
    exu_pkg::data_t      res_sel;

    assign accept    = md.start & ~md.busy;
    assign last_step = (cnt_q == CNT_W'(exu_pkg::MD_STEPS - 1));

    // operand signedness per op
    assign is_div = md.op inside {exu_pkg::MD_DIV, exu_pkg::MD_DIVU,
                                  exu_pkg::MD_REM, exu_pkg::MD_REMU};
    assign neg1 = md.op1[31] & (md.op inside {exu_pkg::MD_MULH, exu_pkg::MD_MULHSU,
                                              exu_pkg::MD_DIV, exu_pkg::MD_REM});
    assign neg2 = md.op2[31] & (md.op inside {exu_pkg::MD_MULH, exu_pkg::MD_DIV,
                                              exu_pkg::MD_REM});
    assign mag1 = neg1 ? -md.op1 : md.op1;
    assign mag2 = neg2 ? -md.op2 : md.op2;

    // multiply: add multiplicand when lsb set, then shift right
    assign add_sum  = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opnd_q} : 33'd0);
    // divide: shift remainder left, try subtracting divisor
    assign sub_diff = {1'b0, hi_q, lo_q[31]} - {2'b00, opnd_q};

    assign prod_fix = neg_res_q ? -{hi_q, lo_q} : {hi_q, lo_q};

    always_comb begin
        case (op_q)
            exu_pkg::MD_MUL:  res_sel = prod_fix[31:0];
            exu_pkg::MD_MULH,
            exu_pkg::MD_MULHSU,
            exu_pkg::MD_MULHU: res_sel = prod_fix[63:32];
            exu_pkg::MD_DIV,
            exu_pkg::MD_DIVU: res_sel = neg_res_q ? -lo_q : lo_q;
            default:          res_sel = neg_rem_q ? -hi_q : hi_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q  <= 1'b0;
            fix_q  <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (md.kill) begin
            // back to idle, pending done is dropped
            run_q  <= 1'b0;
            fix_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= fix_q;
            fix_q  <= run_q & last_step;
            if (accept) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                run_q <= ~last_step;
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= md.op;
            div_q     <= is_div;
            // x/0 keeps an all-ones quotient whatever the sign
            neg_res_q <= (neg1 ^ neg2) & (md.op2 != '0);
            neg_rem_q <= neg1;
            hi_q      <= '0;
            lo_q      <= is_div ? mag1 : mag2;
            opnd_q    <= is_div ? mag2 : mag1;
        end else if (run_q && div_q) begin
            hi_q <= sub_diff[33] ? {hi_q[30:0], lo_q[31]} : sub_diff[31:0];
            lo_q <= {lo_q[30:0], ~sub_diff[33]};
        end else if (run_q) begin
            hi_q <= add_sum[32:1];
            lo_q <= {add_sum[0], lo_q[31:1]};
        end else if (fix_q) begin
            result_q <= res_sel;
        end
    end

    assign md.busy   = run_q | fix_q;
    assign md.done   = done_q;
    assign md.result = result_q;

endmodule

`default_nettype wire

// ==== hw/exu_top.sv ====
/*
 Execute stage top for the RV32 in-order core.
 ALU and branch results retire in the same cycle; multiply and divide
 hold upstream until their write-back. An interrupt redirects to its
 address, squashes the write and kills any running M operation.
 */
`timescale 1ns/1ns
`default_nettype none

module exu_top (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire exu_pkg::dec_info_t dec_info_i,
    input  wire exu_pkg::data_t     dec_imm_i,
    input  wire exu_pkg::data_t     pc_i,
    input  wire exu_pkg::data_t     rs1_rdata_i,
    input  wire exu_pkg::data_t     rs2_rdata_i,
    input  wire exu_pkg::reg_addr_t rd_addr_i,
    input  wire                     rd_we_i,
    input  wire                     int_assert_i,
    input  wire exu_pkg::data_t     int_addr_i,
    output logic                    reg_we_o,
    output exu_pkg::reg_addr_t      reg_waddr_o,
    output exu_pkg::data_t          reg_wdata_o,
    output logic                    jump_flag_o,
    output exu_pkg::data_t          jump_addr_o,
    output logic                    hold_flag_o
);

    logic           alu_we;
    exu_pkg::data_t alu_result;
    logic           bru_jump;
    exu_pkg::data_t bru_target;
    logic           bru_we;
    exu_pkg::data_t bru_link;
    logic           md_hold;
    logic           md_we;
    exu_pkg::data_t md_result;

    issue_if  iss ();
    muldiv_if md ();

    exu_dispatch u_exu_dispatch (
        .dec_info_i (dec_info_i),  .dec_imm_i   (dec_imm_i),
        .pc_i       (pc_i),        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i(rs2_rdata_i), .int_assert_i(int_assert_i),
        .iss        (iss.dispatch)
    );

    exu_alu u_exu_alu (
        .iss(iss.alu), .alu_we_o(alu_we), .alu_result_o(alu_result)
    );

    exu_bru u_exu_bru (
        .iss         (iss.bru),
        .bru_jump_o  (bru_jump), .bru_target_o(bru_target),
        .bru_we_o    (bru_we),   .bru_link_o  (bru_link)
    );

    exu_muldiv_ctrl u_exu_muldiv_ctrl (
        .clk      (clk),        .rst_n_i     (rst_n_i),
        .iss      (iss.muldiv), .int_assert_i(int_assert_i),
        .md       (md.ctrl),    .md_hold_o   (md_hold),
        .md_we_o  (md_we),      .md_result_o (md_result)
    );

    exu_muldiv_core u_exu_muldiv_core (
        .clk(clk), .rst_n_i(rst_n_i), .md(md.core)
    );

    // write-back priority: M result, link, ALU
    assign reg_wdata_o = md_we  ? md_result :
                         bru_we ? bru_link  : alu_result;
    assign reg_we_o    = (md_we | bru_we | alu_we) & rd_we_i & ~int_assert_i;
    assign reg_waddr_o = rd_addr_i;

    // interrupt redirect wins over any branch
    assign jump_flag_o = int_assert_i | bru_jump;
    assign jump_addr_o = int_assert_i ? int_addr_i : bru_target;
    assign hold_flag_o = md_hold;

endmodule

`default_nettype wire

// ==== tests/exu_ref.svh ====
/*
 Reference model for the execute stage testbench, included inside it.
 Gives expected ALU, branch and M-extension results from the RV32IM rules.
 ALU codes: 0 lui, 1 auipc, 2 add, 3 sub, 4 sll, 5 slt, 6 sltu, 7 xor,
 8 srl, 9 sra, 10 or, 11 and.
 Branch codes: 0 jal, 1 jalr, 2 beq, 3 bne, 4 blt, 5 bltu, 6 bge, 7 bgeu.
 */
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// value written to rd, b is already rs2 or the immediate
function automatic exu_pkg::data_t alu_result_of(input int code, input exu_pkg::data_t pc,
        input exu_pkg::data_t imm, input exu_pkg::data_t a, input exu_pkg::data_t b);
    case (code)
        0: return imm;
        1: return pc + imm;
        2: return a + b;
        3: return a - b;
        4: return a << b[4:0];
        5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        6: return (a < b) ? 32'd1 : 32'd0;
        7: return a ^ b;
        8: return a >> b[4:0];
        9: return exu_pkg::data_t'($signed(a) >>> b[4:0]);
        10: return a | b;
        default: return a & b;
    endcase
endfunction

// jumps always go, branches compare rs1 with rs2
function automatic logic branch_taken(input int code, input exu_pkg::data_t a,
        input exu_pkg::data_t b);
    case (code)
        0, 1: return 1'b1;
        2: return a == b;
        3: return a != b;
        4: return $signed(a) < $signed(b);
        5: return a < b;
        6: return $signed(a) >= $signed(b);
        default: return a >= b;
    endcase
endfunction

// jalr is rs1 relative with bit zero cleared, the rest pc relative
function automatic exu_pkg::data_t jump_target(input int code, input exu_pkg::data_t pc,
        input exu_pkg::data_t rs1, input exu_pkg::data_t imm);
    exu_pkg::data_t t;
    t = (code == 1) ? rs1 + imm : pc + imm;
    if (code == 1) begin
        t[0] = 1'b0;
    end
    return t;
endfunction

function automatic exu_pkg::data_t muldiv_result_of(input exu_pkg::muldiv_op_e op,
        input exu_pkg::data_t a, input exu_pkg::data_t b);
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    // low 64 bits of the extended product are exact for any signedness
    case (op)
        exu_pkg::MD_MUL, exu_pkg::MD_MULH: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        exu_pkg::MD_MULHSU: prod = {{32{a[31]}}, a} * {32'd0, b};
        default: prod = {32'd0, a} * {32'd0, b};
    endcase
    case (op)
        exu_pkg::MD_MUL: return prod[31:0];
        exu_pkg::MD_MULH, exu_pkg::MD_MULHSU, exu_pkg::MD_MULHU: return prod[63:32];
        exu_pkg::MD_DIV: begin
            if (b == 32'd0) return '1;
            // most negative over minus one overflows back to itself
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
            return sa / sb;
        end
        exu_pkg::MD_DIVU: return (b == 32'd0) ? '1 : a / b;
        exu_pkg::MD_REM: begin
            if (b == 32'd0) return a;
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
            return sa % sb;
        end
        default: return (b == 32'd0) ? a : a % b;
    endcase
endfunction

`endif

// ==== tests/tb_exu_top.sv ====
/*
 Testbench for the RV32 execute stage top.
 Drives random ALU, branch, multiply/divide and interrupt cases on the
 falling edge and checks the outputs a quarter period after each rising
 edge against the reference model. Stops at the first error.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_exu_top;

    localparam int CLK_PERIOD = 20;
    localparam int N_ALU      = 80;
    localparam int N_BRANCH   = 60;
    localparam int N_MULDIV   = 40;
    localparam int N_INT      = 6;
    // about 200 instructions at up to 40 cycles each
    localparam int MAX_CYCLES = 200 * 40;
    // what the compare process expects this cycle
    localparam int MODE_OFF   = 0;
    localparam int MODE_SAME  = 1;
    localparam int MODE_MD    = 2;

    logic               clk;
    logic               rst_n_i;
    exu_pkg::dec_info_t dec_info_i;
    exu_pkg::data_t     dec_imm_i;
    exu_pkg::data_t     pc_i;
    exu_pkg::data_t     rs1_rdata_i;
    exu_pkg::data_t     rs2_rdata_i;
    exu_pkg::reg_addr_t rd_addr_i;
    logic               rd_we_i;
    logic               int_assert_i;
    exu_pkg::data_t     int_addr_i;
    logic               reg_we_o;
    exu_pkg::reg_addr_t reg_waddr_o;
    exu_pkg::data_t     reg_wdata_o;
    logic               jump_flag_o;
    exu_pkg::data_t     jump_addr_o;
    logic               hold_flag_o;

    // expectations, set on the falling edge with the inputs
    int                 mode;
    int                 md_age;
    logic               exp_we;
    exu_pkg::data_t     exp_wdata;
    logic               exp_jump;
    exu_pkg::data_t     exp_jaddr;
    int                 cycles;
    integer             seed;

    `include "exu_ref.svh"

    exu_top exu_top_i (
        .clk(clk), .rst_n_i(rst_n_i), .dec_info_i(dec_info_i), .dec_imm_i(dec_imm_i),
        .pc_i(pc_i), .rs1_rdata_i(rs1_rdata_i), .rs2_rdata_i(rs2_rdata_i),
        .rd_addr_i(rd_addr_i), .rd_we_i(rd_we_i), .int_assert_i(int_assert_i),
        .int_addr_i(int_addr_i), .reg_we_o(reg_we_o), .reg_waddr_o(reg_waddr_o),
        .reg_wdata_o(reg_wdata_o), .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o),
        .hold_flag_o(hold_flag_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input exu_pkg::data_t act,
                              input exu_pkg::data_t exp);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_addr(input string name, input exu_pkg::reg_addr_t act,
                              input exu_pkg::reg_addr_t exp);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    // cycle limit so a stuck hold cannot hang the run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error($sformatf("timeout: tests not finished after %0d cycles", cycles));
        end
    end

    // compare process, samples well away from both clock edges
    always @(posedge clk) begin
        #(CLK_PERIOD / 4);
        if (mode == MODE_SAME) begin
            check_flag("reg_we_o", reg_we_o, exp_we);
            if (exp_we) begin
                check_addr("reg_waddr_o", reg_waddr_o, rd_addr_i);
                check_data("reg_wdata_o", reg_wdata_o, exp_wdata);
            end
            check_flag("jump_flag_o", jump_flag_o, exp_jump);
            if (exp_jump) begin
                check_data("jump_addr_o", jump_addr_o, exp_jaddr);
            end
            check_flag("hold_flag_o", hold_flag_o, 1'b0);
        end else if (mode == MODE_MD) begin
            check_flag("jump_flag_o", jump_flag_o, 1'b0);
            // multi-cycle op always holds in its first cycle
            if (md_age == 0) begin
                check_flag("hold_flag_o", hold_flag_o, 1'b1);
            end
            if (hold_flag_o === 1'b1) begin
                check_flag("reg_we_o", reg_we_o, 1'b0);
            end else begin
                check_flag("reg_we_o", reg_we_o, 1'b1);
                check_addr("reg_waddr_o", reg_waddr_o, rd_addr_i);
                check_data("reg_wdata_o", reg_wdata_o, exp_wdata);
            end
            md_age = md_age + 1;
        end
    end

    // mostly random, with the usual corner values mixed in
    function automatic exu_pkg::data_t random_word();
        int pick;
        pick = $random(seed) & 7;
        case (pick)
            0: return 32'h0;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic exu_pkg::alu_ops_t alu_ops_for(input int code, input logic use_imm);
        exu_pkg::alu_ops_t ops;
        ops = '0;
        ops.op2_imm = use_imm;
        case (code)
            0: ops.op_lui = 1'b1;
            1: ops.op_auipc = 1'b1;
            2: ops.op_add = 1'b1;
            3: ops.op_sub = 1'b1;
            4: ops.op_sll = 1'b1;
            5: ops.op_slt = 1'b1;
            6: ops.op_sltu = 1'b1;
            7: ops.op_xor = 1'b1;
            8: ops.op_srl = 1'b1;
            9: ops.op_sra = 1'b1;
            10: ops.op_or = 1'b1;
            default: ops.op_and = 1'b1;
        endcase
        return ops;
    endfunction

    function automatic exu_pkg::bjp_ops_t bjp_ops_for(input int code);
        exu_pkg::bjp_ops_t ops;
        ops = '0;
        case (code)
            0: ops.op_jal = 1'b1;
            1: ops.op_jalr = 1'b1;
            2: ops.op_beq = 1'b1;
            3: ops.op_bne = 1'b1;
            4: ops.op_blt = 1'b1;
            5: ops.op_bltu = 1'b1;
            6: ops.op_bge = 1'b1;
            default: ops.op_bgeu = 1'b1;
        endcase
        return ops;
    endfunction

    task automatic idle_step();
        dec_info_i.grp = exu_pkg::GRP_NONE;
        dec_info_i.ops = '0;
        // rd_we high, so any stray write shows up
        rd_we_i  = 1'b1;
        exp_we   = 1'b0;
        exp_jump = 1'b0;
        mode     = MODE_SAME;
        @(negedge clk);
    endtask

    task automatic alu_step();
        int             code;
        logic           use_imm;
        exu_pkg::data_t b;
        code               = int'({$random(seed)} % 12);
        use_imm            = 1'($random(seed));
        dec_info_i.grp     = exu_pkg::GRP_ALU;
        dec_info_i.ops.alu = alu_ops_for(code, use_imm);
        dec_imm_i          = random_word();
        pc_i               = {$random(seed)} & 32'hffff_fffc;
        rs1_rdata_i        = random_word();
        rs2_rdata_i        = random_word();
        rd_addr_i          = 5'($random(seed));
        // write enable off for about one op in eight
        rd_we_i            = (($random(seed) & 7) != 0);
        b                  = use_imm ? dec_imm_i : rs2_rdata_i;
        exp_we             = rd_we_i;
        exp_wdata          = alu_result_of(code, pc_i, dec_imm_i, rs1_rdata_i, b);
        exp_jump           = 1'b0;
        mode               = MODE_SAME;
        @(negedge clk);
    endtask

    task automatic branch_step();
        int code;
        code               = int'({$random(seed)} % 8);
        dec_info_i.grp     = exu_pkg::GRP_BJP;
        dec_info_i.ops.bjp = bjp_ops_for(code);
        dec_imm_i          = random_word() & 32'hffff_fffe;
        pc_i               = {$random(seed)} & 32'hffff_fffc;
        rs1_rdata_i        = random_word();
        // equal operands now and then for the eq and ge cases
        if (($random(seed) & 3) == 0) begin
            rs2_rdata_i = rs1_rdata_i;
        end else begin
            rs2_rdata_i = random_word();
        end
        rd_addr_i = 5'($random(seed));
        rd_we_i   = (($random(seed) & 7) != 0);
        exp_jump  = branch_taken(code, rs1_rdata_i, rs2_rdata_i);
        exp_jaddr = jump_target(code, pc_i, rs1_rdata_i, dec_imm_i);
        // only jal and jalr link
        exp_we    = rd_we_i & (code < 2);
        exp_wdata = pc_i + exu_pkg::INST_BYTES;
        mode      = MODE_SAME;
        @(negedge clk);
    endtask

    task automatic muldiv_issue(input exu_pkg::muldiv_op_e op, input exu_pkg::data_t a,
                                input exu_pkg::data_t b);
        dec_info_i.grp       = exu_pkg::GRP_MULDIV;
        dec_info_i.ops       = '0;
        dec_info_i.ops.md.op = op;
        dec_imm_i            = $random(seed);
        pc_i                 = {$random(seed)} & 32'hffff_fffc;
        rs1_rdata_i          = a;
        rs2_rdata_i          = b;
        rd_addr_i            = 5'($random(seed));
        rd_we_i              = 1'b1;
        exp_we               = 1'b1;
        exp_wdata            = muldiv_result_of(op, a, b);
        exp_jump             = 1'b0;
        md_age               = 0;
        mode                 = MODE_MD;
    endtask

    task automatic muldiv_step(input exu_pkg::muldiv_op_e op, input exu_pkg::data_t a,
                               input exu_pkg::data_t b);
        muldiv_issue(op, a, b);
        // same instruction stays on the inputs until hold drops
        do begin
            @(negedge clk);
        end while (hold_flag_o !== 1'b0);
    endtask

    task automatic interrupt_step();
        int wait_cycles;
        wait_cycles = 1 + int'({$random(seed)} % 20);
        muldiv_issue(exu_pkg::muldiv_op_e'(3'($random(seed))), random_word(), random_word());
        repeat (wait_cycles) @(negedge clk);
        // interrupt hits while the op is still held
        int_assert_i = 1'b1;
        int_addr_i   = {$random(seed)} & 32'hffff_fffc;
        exp_we       = 1'b0;
        exp_jump     = 1'b1;
        exp_jaddr    = int_addr_i;
        mode         = MODE_SAME;
        @(negedge clk);
        int_assert_i = 1'b0;
        idle_step();
        // killed op must not leak into the next one
        muldiv_step(exu_pkg::muldiv_op_e'(3'($random(seed))), random_word(), random_word());
    endtask

    initial begin
        seed         = 73357;
        cycles       = 0;
        mode         = MODE_OFF;
        md_age       = 0;
        exp_we       = 1'b0;
        exp_wdata    = '0;
        exp_jump     = 1'b0;
        exp_jaddr    = '0;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        dec_info_i   = '0;
        dec_imm_i    = '0;
        pc_i         = '0;
        rs1_rdata_i  = '0;
        rs2_rdata_i  = '0;
        rd_addr_i    = '0;
        rd_we_i      = 1'b0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        // idle after reset
        idle_step();
        repeat (N_ALU) alu_step();
        repeat (N_BRANCH) branch_step();
        // divide by zero for every op, then signed overflow
        for (int i = 0; i < 8; i++) begin
            muldiv_step(exu_pkg::muldiv_op_e'(i), random_word(), 32'h0);
        end
        muldiv_step(exu_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff);
        muldiv_step(exu_pkg::MD_REM, 32'h8000_0000, 32'hffff_ffff);
        repeat (N_MULDIV) begin
            muldiv_step(exu_pkg::muldiv_op_e'(3'($random(seed))), random_word(),
                        random_word());
        end
        repeat (N_INT) interrupt_step();
        idle_step();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exu.f ====
+incdir+tests
common/exu_pkg.sv
common/issue_if.sv
common/muldiv_if.sv
hw/exu_dispatch.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/muldiv/exu_muldiv_ctrl.sv
hw/muldiv/exu_muldiv_core.sv
hw/exu_top.sv
tests/tb_exu_top.sv

// ==== Makefile ====
SIM        ?= verilator
TOP        ?= tb_exu_top
RTL_TOP    ?= exu_top
FILELIST   ?= exu.f
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
